// File: maze_pkg.sv
`default_nettype none

package maze_pkg;

	localparam int GRID_BITS = 4;
	localparam int GRID_CELLS = 1 << (2 * GRID_BITS);

	typedef logic [GRID_BITS-1:0] coord_t;
	typedef logic [2*GRID_BITS-1:0] cell_addr_t; // {y, x}
	typedef logic [1:0] dir_t;

	localparam coord_t COORD_MAX = '1; // Last row or column

	localparam dir_t DIR_EAST = 2'd0;  // x+1
	localparam dir_t DIR_SOUTH = 2'd1; // y+1
	localparam dir_t DIR_WEST = 2'd2;  // x-1
	localparam dir_t DIR_NORTH = 2'd3; // y-1, last one tried

	// {x, y, dir} where dir is the move taken out of the cell
	typedef logic [2*GRID_BITS+1:0] step_t;

endpackage

`default_nettype wire

// File: maze_map.sv
`timescale 1ns/100ps
`default_nettype none

module maze_map (
	input wire CLK,
	input wire load_en,
	input wire maze_pkg::cell_addr_t load_addr,
	input wire load_wall,
	input wire mark,
	input wire maze_pkg::cell_addr_t cur_addr,
	input wire maze_pkg::cell_addr_t nbr_addr,
	output logic nbr_wall
);

	// One bit per cell, set means wall or already visited
	logic cells [0:maze_pkg::GRID_CELLS-1];

	always_ff @(posedge CLK) begin
		if (load_en)
			cells[load_addr] <= load_wall;
		else if (mark)
			cells[cur_addr] <= 1'b1; // Visited cells become walls
	end

	assign nbr_wall = cells[nbr_addr];

	// The map may only be loaded while no search is running
	a_no_load_in_search: assert property (@(posedge CLK) !(load_en && mark))
		else $error("map loaded during a search");

endmodule

`default_nettype wire

// File: position_unit.sv
`timescale 1ns/100ps
`default_nettype none

module position_unit #(
	parameter int GOAL_X = 15,
	parameter int GOAL_Y = 15
) (
	input wire CLK,
	input wire RST,
	input wire init_pos,
	input wire next_dir,
	input wire advance,
	input wire restore,
	input wire maze_pkg::step_t restore_step,
	input wire nbr_wall,
	output maze_pkg::cell_addr_t cur_addr,
	output maze_pkg::cell_addr_t nbr_addr,
	output maze_pkg::step_t cur_step,
	output logic blocked,
	output logic at_goal,
	output logic dir_last
);

	maze_pkg::coord_t x, y;
	maze_pkg::coord_t nbr_x, nbr_y;
	maze_pkg::coord_t rest_x, rest_y;
	maze_pkg::dir_t dir, rest_dir;
	logic off_grid;

	assign {rest_x, rest_y, rest_dir} = restore_step;

	always_comb begin
		nbr_x = x;
		nbr_y = y;
		case (dir)
			maze_pkg::DIR_EAST: nbr_x = x + 1'b1;
			maze_pkg::DIR_SOUTH: nbr_y = y + 1'b1;
			maze_pkg::DIR_WEST: nbr_x = x - 1'b1;
			default: nbr_y = y - 1'b1;
		endcase
	end

	// Wrapped neighbor addresses are hidden by this test
	assign off_grid = (dir == maze_pkg::DIR_EAST && x == maze_pkg::COORD_MAX) ||
		(dir == maze_pkg::DIR_SOUTH && y == maze_pkg::COORD_MAX) ||
		(dir == maze_pkg::DIR_WEST && x == '0) ||
		(dir == maze_pkg::DIR_NORTH && y == '0);

	assign blocked = off_grid | nbr_wall;
	assign at_goal = (x == maze_pkg::coord_t'(GOAL_X)) && (y == maze_pkg::coord_t'(GOAL_Y));
	// During a restore this reports the direction being restored
	assign dir_last = restore ? (rest_dir == maze_pkg::DIR_NORTH) : (dir == maze_pkg::DIR_NORTH);

	assign cur_addr = {y, x};
	assign nbr_addr = {nbr_y, nbr_x};
	assign cur_step = {x, y, dir};

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			x <= '0;
			y <= '0;
			dir <= maze_pkg::DIR_EAST;
		end else if (init_pos) begin
			x <= '0;
			y <= '0;
			dir <= maze_pkg::DIR_EAST;
		end else if (restore) begin
			x <= rest_x;
			y <= rest_y;
			dir <= rest_dir + 1'b1; // Resume with the next direction
		end else if (advance) begin
			x <= nbr_x;
			y <= nbr_y;
			dir <= maze_pkg::DIR_EAST;
		end else if (next_dir) begin
			dir <= dir + 1'b1;
		end
	end

	a_advance_open: assert property (@(posedge CLK) disable iff (RST) advance |-> !blocked)
		else $error("advance into a blocked cell");

endmodule

`default_nettype wire

// File: step_stack.sv
`timescale 1ns/100ps
`default_nettype none

module step_stack #(
	parameter int STACK_DEPTH = 256
) (
	input wire CLK,
	input wire RST,
	input wire init_stack,
	input wire push,
	input wire pop,
	input wire maze_pkg::step_t push_step,
	output maze_pkg::step_t top_step,
	output logic stack_empty
);

	localparam int IDX_W = $clog2(STACK_DEPTH);
	localparam int CNT_W = $clog2(STACK_DEPTH + 1);

	maze_pkg::step_t mem [0:STACK_DEPTH-1];
	logic [CNT_W-1:0] count;

	always_ff @(posedge CLK) begin
		if (push)
			mem[IDX_W'(count)] <= push_step;
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			count <= '0;
		else if (init_stack)
			count <= '0;
		else if (push)
			count <= count + 1'b1;
		else if (pop)
			count <= count - 1'b1;
	end

	assign top_step = mem[IDX_W'(count - 1'b1)]; // Newest entry
	assign stack_empty = (count == '0);

	a_no_underflow: assert property (@(posedge CLK) disable iff (RST) pop |-> !stack_empty)
		else $error("pop from an empty stack");
	a_no_overflow: assert property (@(posedge CLK) disable iff (RST)
		push |-> count != CNT_W'(STACK_DEPTH))
		else $error("push into a full stack");

endmodule

`default_nettype wire

// File: path_list.sv
`timescale 1ns/100ps
`default_nettype none

module path_list #(
	parameter int STACK_DEPTH = 256
) (
	input wire CLK,
	input wire RST,
	input wire init_list,
	input wire list_push,
	input wire en_read,
	input wire maze_pkg::step_t push_step,
	output logic move_valid,
	output maze_pkg::step_t move_step,
	output logic complete_read
);

	localparam int IDX_W = $clog2(STACK_DEPTH);
	localparam int CNT_W = $clog2(STACK_DEPTH + 1);

	maze_pkg::step_t mem [0:STACK_DEPTH-1];
	logic [CNT_W-1:0] wr_cnt;
	logic [IDX_W-1:0] rd_ptr;
	logic [IDX_W-1:0] rd_idx;
	logic en_read_d;

	// Entry 0 is the step next to the goal, so read from the top down
	assign rd_idx = en_read_d ? rd_ptr : IDX_W'(wr_cnt - 1'b1);

	always_ff @(posedge CLK) begin
		if (list_push)
			mem[IDX_W'(wr_cnt)] <= push_step;
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			wr_cnt <= '0;
			rd_ptr <= '0;
			en_read_d <= 1'b0;
		end else begin
			en_read_d <= en_read;
			if (init_list)
				wr_cnt <= '0;
			else if (list_push)
				wr_cnt <= wr_cnt + 1'b1;
			if (en_read)
				rd_ptr <= rd_idx - 1'b1;
		end
	end

	assign move_step = mem[rd_idx];
	assign move_valid = en_read && (wr_cnt != '0);
	assign complete_read = en_read && (wr_cnt == '0 || rd_idx == '0); // Last step or empty path

endmodule

`default_nettype wire

// File: maze_controller.sv
`timescale 1ns/100ps
`default_nettype none

module maze_controller (
	input wire CLK,
	input wire RST,
	input wire start,
	input wire run,
	input wire blocked,
	input wire at_goal,
	input wire dir_last,
	input wire stack_empty,
	input wire complete_read,
	output logic init_pos,
	output logic next_dir,
	output logic advance,
	output logic restore,
	output logic mark,
	output logic init_stack,
	output logic push,
	output logic pop,
	output logic init_list,
	output logic list_push,
	output logic en_read,
	output logic done,
	output logic fail
);

	typedef enum logic [3:0] {
		idle, init, mark_cell, check_goal, try_dir, turn_dir, push_step, advance_st,
		backtrack, pop_step, collect, collect_step, fail_st, done_st, show
	} state_t;

	state_t state, next_state;

	always_comb begin
		next_state = state;
		case (state)
			idle: if (start) next_state = init;
			init: next_state = mark_cell;
			mark_cell: next_state = check_goal;
			check_goal: next_state = at_goal ? collect : try_dir;
			try_dir: begin
				if (!blocked)
					next_state = push_step;
				else if (!dir_last)
					next_state = turn_dir;
				else
					next_state = backtrack; // Every direction used up
			end
			turn_dir: next_state = try_dir;
			push_step: next_state = advance_st;
			advance_st: next_state = mark_cell;
			backtrack: next_state = stack_empty ? fail_st : pop_step;
			pop_step: next_state = dir_last ? backtrack : try_dir;
			collect: next_state = stack_empty ? done_st : collect_step;
			collect_step: next_state = collect;
			fail_st: if (start) next_state = init;
			done_st: begin
				if (start)
					next_state = init;
				else if (run)
					next_state = show;
			end
			show: if (complete_read) next_state = done_st;
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			state <= idle;
		else
			state <= next_state;
	end

	// Strobes decode the registered state only
	assign init_pos = (state == init);
	assign init_stack = (state == init);
	assign init_list = (state == init);
	assign mark = (state == mark_cell);
	assign next_dir = (state == turn_dir);
	assign push = (state == push_step);
	assign advance = (state == advance_st);
	assign restore = (state == pop_step);
	assign pop = (state == pop_step) || (state == collect_step);
	assign list_push = (state == collect_step); // Stack top moves into the list
	assign en_read = (state == show);
	assign done = (state == done_st) || (state == show);
	assign fail = (state == fail_st);

endmodule

`default_nettype wire

// File: maze_solver.sv
`timescale 1ns/100ps
`default_nettype none

module maze_solver #(
	parameter int STACK_DEPTH = 256,
	parameter int GOAL_X = 15,
	parameter int GOAL_Y = 15
) (
	input wire CLK,
	input wire RST,
	input wire start,
	input wire run,
	input wire load_en,
	input wire maze_pkg::cell_addr_t load_addr,
	input wire load_wall,
	output logic done,
	output logic fail,
	output logic move_valid,
	output maze_pkg::coord_t move_x,
	output maze_pkg::coord_t move_y,
	output maze_pkg::dir_t move_dir
);

	logic init_pos, next_dir, advance, restore, mark;
	logic init_stack, push, pop, init_list, list_push, en_read;
	logic blocked, at_goal, dir_last, stack_empty, complete_read;
	logic nbr_wall;
	maze_pkg::cell_addr_t cur_addr, nbr_addr;
	maze_pkg::step_t cur_step, top_step, move_step;

	assign {move_x, move_y, move_dir} = move_step;

	maze_controller maze_controller_inst (
		.CLK(CLK), .RST(RST), .start(start), .run(run),
		.blocked(blocked), .at_goal(at_goal), .dir_last(dir_last),
		.stack_empty(stack_empty), .complete_read(complete_read),
		.init_pos(init_pos), .next_dir(next_dir), .advance(advance), .restore(restore),
		.mark(mark), .init_stack(init_stack), .push(push), .pop(pop),
		.init_list(init_list), .list_push(list_push), .en_read(en_read),
		.done(done), .fail(fail)
	);

	maze_map maze_map_inst (
		.CLK(CLK), .load_en(load_en), .load_addr(load_addr), .load_wall(load_wall),
		.mark(mark), .cur_addr(cur_addr), .nbr_addr(nbr_addr), .nbr_wall(nbr_wall)
	);

	position_unit #(.GOAL_X(GOAL_X), .GOAL_Y(GOAL_Y)) position_unit_inst (
		.CLK(CLK), .RST(RST), .init_pos(init_pos), .next_dir(next_dir),
		.advance(advance), .restore(restore), .restore_step(top_step),
		.nbr_wall(nbr_wall), .cur_addr(cur_addr), .nbr_addr(nbr_addr),
		.cur_step(cur_step), .blocked(blocked), .at_goal(at_goal), .dir_last(dir_last)
	);

	step_stack #(.STACK_DEPTH(STACK_DEPTH)) step_stack_inst (
		.CLK(CLK), .RST(RST), .init_stack(init_stack), .push(push), .pop(pop),
		.push_step(cur_step), .top_step(top_step), .stack_empty(stack_empty)
	);

	path_list #(.STACK_DEPTH(STACK_DEPTH)) path_list_inst (
		.CLK(CLK), .RST(RST), .init_list(init_list), .list_push(list_push),
		.en_read(en_read), .push_step(top_step), .move_valid(move_valid),
		.move_step(move_step), .complete_read(complete_read)
	);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic RST
);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK; // 10 ns period

	initial begin
		RST = 1'b1;
		repeat (5) @(posedge CLK);
		#1 RST = 1'b0;
	end

endmodule

`default_nettype wire

// File: maze_solver_tb.sv
`timescale 1ns/100ps
`default_nettype none

module maze_solver_tb;

	localparam int GOAL_X = 15;
	localparam int GOAL_Y = 15;
	localparam maze_pkg::cell_addr_t GOAL_ADDR = maze_pkg::cell_addr_t'(GOAL_Y * 16 + GOAL_X);
	localparam int NUM_MAZES = 10;
	localparam int MAZE_CYCLES = 256 + 256 * 12 + 600; // Load, search and replay

	logic CLK, RST;
	logic start, run, load_en, load_wall;
	maze_pkg::cell_addr_t load_addr;
	logic done, fail, move_valid;
	maze_pkg::coord_t move_x, move_y, exp_x, exp_y;
	maze_pkg::dir_t move_dir;
	logic [255:0] wall_map;
	logic [255:0] seen; // Cells already replayed
	maze_pkg::step_t rec [0:255];
	logic [31:0] seed;
	logic started, expect_reach, check_result, check_end, rewind;
	int replay_idx, step_idx, rec_len;

	tb_clock_gen tb_clock_gen_inst (.CLK(CLK), .RST(RST));

	maze_solver #(.STACK_DEPTH(256), .GOAL_X(GOAL_X), .GOAL_Y(GOAL_Y)) maze_solver_inst (
		.CLK(CLK), .RST(RST), .start(start), .run(run),
		.load_en(load_en), .load_addr(load_addr), .load_wall(load_wall),
		.done(done), .fail(fail), .move_valid(move_valid),
		.move_x(move_x), .move_y(move_y), .move_dir(move_dir)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic leaves_grid(input maze_pkg::coord_t x, input maze_pkg::coord_t y,
		input maze_pkg::dir_t d);
		case (d)
			maze_pkg::DIR_EAST: return x == 4'hf;
			maze_pkg::DIR_SOUTH: return y == 4'hf;
			maze_pkg::DIR_WEST: return x == 4'h0;
			default: return y == 4'h0;
		endcase
	endfunction

	function automatic maze_pkg::coord_t next_x(input maze_pkg::coord_t x, input maze_pkg::dir_t d);
		if (d == maze_pkg::DIR_EAST)
			return x + 4'd1;
		if (d == maze_pkg::DIR_WEST)
			return x - 4'd1;
		return x;
	endfunction

	function automatic maze_pkg::coord_t next_y(input maze_pkg::coord_t y, input maze_pkg::dir_t d);
		if (d == maze_pkg::DIR_SOUTH)
			return y + 4'd1;
		if (d == maze_pkg::DIR_NORTH)
			return y - 4'd1;
		return y;
	endfunction

	// Flood fill from (0,0) over the loaded walls
	function automatic logic goal_reachable();
		logic [255:0] reach;
		logic grown;
		int x, y;
		reach = '0;
		reach[0] = 1'b1;
		grown = 1'b1;
		while (grown) begin
			grown = 1'b0;
			for (int a = 0; a < 256; a++) begin
				x = a % 16;
				y = a / 16;
				if (!reach[a] && !wall_map[a] && ((x < 15 && reach[a+1]) || (x > 0 && reach[a-1]) ||
					(y < 15 && reach[a+16]) || (y > 0 && reach[a-16]))) begin
					reach[a] = 1'b1;
					grown = 1'b1;
				end
			end
		end
		return reach[GOAL_ADDR];
	endfunction

	task automatic report_failure(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	// Maze 0 is open, maze 1 has its goal walled in, the rest are random
	task automatic make_maze(input int kind);
		for (int a = 0; a < 256; a++) begin
			seed = lcg_next(seed);
			if (kind == 0)
				wall_map[a] = 1'b0;
			else if (kind == 1)
				wall_map[a] = (a == 8'hfe || a == 8'hef);
			else
				wall_map[a] = (seed[30:16] % 100) < 30;
		end
		wall_map[0] = 1'b0;
		wall_map[GOAL_ADDR] = 1'b0;
	endtask

	task automatic load_map();
		for (int a = 0; a < 256; a++) begin
			load_en = 1'b1;
			load_addr = maze_pkg::cell_addr_t'(a);
			load_wall = wall_map[a];
			@(posedge CLK);
			#1;
		end
		load_en = 1'b0;
	endtask

	task automatic replay_path(input int idx);
		replay_idx = idx;
		rewind = 1'b1;
		run = 1'b1;
		@(posedge CLK);
		#1;
		rewind = 1'b0;
		while (move_valid) begin
			@(posedge CLK);
			#1;
		end
		run = 1'b0; // Back in done, so the replay does not restart
		check_end = 1'b1;
		@(posedge CLK);
		#1;
		check_end = 1'b0;
		if (idx == 0)
			rec_len = step_idx;
	endtask

	task automatic solve_maze();
		load_map();
		expect_reach = goal_reachable();
		start = 1'b1;
		started = 1'b1;
		@(posedge CLK);
		#1;
		start = 1'b0;
		while (!(done || fail)) begin
			@(posedge CLK);
			#1;
		end
		check_result = 1'b1;
		@(posedge CLK);
		#1;
		check_result = 1'b0;
		if (expect_reach) begin
			replay_path(0);
			replay_path(1);
		end
	endtask

	// Follows the replayed path one step behind the DUT
	always @(posedge CLK) begin
		if (rewind) begin
			exp_x <= '0;
			exp_y <= '0;
			step_idx <= 0;
			seen <= '0;
		end else if (move_valid) begin
			seen[{move_y, move_x}] <= 1'b1;
			exp_x <= next_x(move_x, move_dir);
			exp_y <= next_y(move_y, move_dir);
			step_idx <= step_idx + 1;
			if (replay_idx == 0)
				rec[step_idx] <= {move_x, move_y, move_dir};
		end
	end

	a_quiet_after_reset: assert property (@(posedge CLK) disable iff (RST)
		!started |-> !done && !fail && !move_valid)
		else report_failure("output active before the first start");
	a_result: assert property (@(posedge CLK)
		check_result |-> done == expect_reach && fail == !expect_reach)
		else report_failure("search result differs from the flood fill");
	a_levels_hold: assert property (@(posedge CLK) disable iff (RST)
		($fell(done) || $fell(fail)) |-> $past(start))
		else report_failure("done or fail dropped without a start");
	a_step_chain: assert property (@(posedge CLK)
		move_valid |-> move_x == exp_x && move_y == exp_y)
		else report_failure("replayed step does not follow the previous one");
	a_step_in_grid: assert property (@(posedge CLK)
		move_valid |-> !leaves_grid(move_x, move_y, move_dir))
		else report_failure("replayed step leaves the grid");
	a_step_clear: assert property (@(posedge CLK)
		move_valid |-> !wall_map[{move_y, move_x}] && !seen[{move_y, move_x}])
		else report_failure("replayed step on a wall or a repeated cell");
	a_same_path: assert property (@(posedge CLK)
		move_valid && replay_idx == 1 |-> {move_x, move_y, move_dir} == rec[step_idx])
		else report_failure("second replay differs from the first");
	a_path_end: assert property (@(posedge CLK) check_end |->
		exp_x == GOAL_X && exp_y == GOAL_Y && (replay_idx == 0 || step_idx == rec_len))
		else report_failure("replay ends off the goal or with a different length");

	initial begin
		start = 1'b0;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_wall = 1'b0;
		seed = 32'h1e5a;
		wall_map = '0;
		started = 1'b0;
		expect_reach = 1'b0;
		check_result = 1'b0;
		check_end = 1'b0;
		rewind = 1'b0;
		replay_idx = 0;
		rec_len = 0;
		@(negedge RST);
		repeat (3) @(posedge CLK);
		#1;
		for (int m = 0; m < NUM_MAZES; m++) begin
			make_maze(m);
			solve_maze();
		end
		repeat (4) @(posedge CLK);
		$display("Simulation finished: PASS");
		$finish;
	end

	initial begin
		#((NUM_MAZES * MAZE_CYCLES + 10) * 10);
		$display("Watchdog timeout: the solver did not finish all mazes in time");
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: flist.f
maze_pkg.sv
maze_map.sv
position_unit.sv
step_stack.sv
path_list.sv
maze_controller.sv
maze_solver.sv
tb_clock_gen.sv
maze_solver_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the maze solver testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module maze_solver_tb \
	-f flist.f -o maze_sim

./obj_dir/maze_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
	echo "run_sim: test passed"
	exit 0
else
	echo "run_sim: test failed, see sim.log"
	exit 1
fi
